/* rtl/l1_cache_cfg.svh */
//************************************************
// size and address map settings for the L1 cache,
// included by the package, the RTL and the testbench
//************************************************
`ifndef L1_CACHE_CFG_SVH
`define L1_CACHE_CFG_SVH

// number of sets, power of two
`define L1_N_SETS 16

// words per block, power of two, max 8
`define L1_BLOCK_WORDS 2

// everything at or above this goes straight to memory
`define L1_NONCACHE_START 32'hF000_0000

`endif

/* rtl/l1_cache_pkg.sv */
//************************************************
// types shared by the cache blocks: address decode,
// frame layout, bus structs and FSM encodings
//************************************************
`include "l1_cache_cfg.svh"

package l1_cache_pkg;

    typedef logic [31:0] word_t;

    localparam int SET_BITS   = $clog2(`L1_N_SETS);
    localparam int BLOCK_BITS = $clog2(`L1_BLOCK_WORDS);
    localparam int TAG_BITS   = 32 - SET_BITS - BLOCK_BITS - 2;

    typedef word_t [`L1_BLOCK_WORDS-1:0] block_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]   tag;
        logic [SET_BITS-1:0]   set_idx;
        logic [BLOCK_BITS-1:0] word_idx;   // word within block
        logic [1:0]            byte_off;
    } cache_addr_t;

    // same address word seen raw or split into fields
    typedef union packed {
        word_t       raw;
        cache_addr_t fields;
    } addr_u;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic [TAG_BITS-1:0] tag;
        block_t              data;
    } frame_t;

    typedef frame_t frame_mask_t;   // 1 keeps the stored bit

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        word_t      wdata;
        logic [3:0] byte_en;
    } proc_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;
    } proc_rsp_t;

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_t      addr;
        block_t     wdata;
        logic [3:0] byte_en;
    } mem_req_t;

    typedef struct packed {
        logic   busy;
        block_t rdata;
    } mem_rsp_t;

    // processor request after decode
    typedef struct packed {
        addr_u addr;
        logic  pass;         // uncached access
        word_t merge_mask;   // 1 keeps the old byte
    } dec_req_t;

    typedef enum logic [2:0] {
        IDLE, HIT, FETCH, WB, FLUSH_CACHE
    } cache_state_t;

    typedef enum logic [2:0] {
        NONE, FETCH_OP, EVICT_OP, FLUSH_OP, PASS_OP
    } mem_op_t;

endpackage

/* rtl/req_decoder.sv */
//************************************************
// decodes the processor request into address fields,
// the uncached flag and a byte merge mask
//************************************************
`timescale 1ns/100ps
`include "l1_cache_cfg.svh"

module req_decoder (
    input  l1_cache_pkg::proc_req_t req,
    output l1_cache_pkg::dec_req_t  dreq,
    output l1_cache_pkg::word_t     lane_wdata
);

    l1_cache_pkg::word_t mask;

    // address split and uncached region check
    always_comb begin
        dreq.addr.raw = req.addr;
        dreq.pass     = (req.addr >= `L1_NONCACHE_START);
    end

    // supported byte patterns, anything else is a full word
    always_comb begin
        case (req.byte_en)
            4'b0001: mask = 32'hFFFF_FF00;
            4'b0010: mask = 32'hFFFF_00FF;
            4'b0100: mask = 32'hFF00_FFFF;
            4'b1000: mask = 32'h00FF_FFFF;
            4'b0011: mask = 32'hFFFF_0000;   // low half
            4'b1100: mask = 32'h0000_FFFF;   // high half
            default: mask = 32'h0000_0000;
        endcase
    end

    assign dreq.merge_mask = mask;

    // store data arrives lane aligned
    // only the enabled bytes go out on an uncached write
    assign lane_wdata = req.wdata & ~mask;

endmodule

/* rtl/frame_store.sv */
//************************************************
// frame array, one frame per set; read is
// combinational, write merges under a bit mask
//************************************************
`timescale 1ns/100ps
`include "l1_cache_cfg.svh"

module frame_store (
    input  logic                              CLK,
    input  logic                              nRST,
    input  logic [l1_cache_pkg::SET_BITS-1:0] rd_set,
    output l1_cache_pkg::frame_t              rd_frame,
    input  logic                              wr_en,
    input  logic [l1_cache_pkg::SET_BITS-1:0] wr_set,
    input  l1_cache_pkg::frame_t              wr_frame,
    input  l1_cache_pkg::frame_mask_t         wr_mask
);

    l1_cache_pkg::frame_t frames [`L1_N_SETS];
    l1_cache_pkg::frame_t merged;

    // keep masked bits, take the rest from the new frame
    assign merged = (frames[wr_set] & wr_mask) | (wr_frame & ~wr_mask);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `L1_N_SETS; i++) begin
                frames[i] <= '0;
            end
        end else if (wr_en) begin
            frames[wr_set] <= merged;
        end
    end

    assign rd_frame = frames[rd_set];

    // controller must hold off its clear pass until reset is released
    no_write_in_reset: assert property (@(posedge CLK) !nRST |-> !wr_en);

endmodule

/* rtl/cache_ctrl.sv */
//************************************************
// cache FSM: hit check, write merge, fill, evict,
// post-reset clear and the flush walk
//************************************************
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                              CLK,
    input  logic                              nRST,
    input  l1_cache_pkg::proc_req_t           req,
    input  l1_cache_pkg::dec_req_t            dreq,
    input  logic                              flush,
    output logic                              flush_done,
    input  l1_cache_pkg::frame_t              rd_frame,
    output logic [l1_cache_pkg::SET_BITS-1:0] rd_set,
    output logic [l1_cache_pkg::SET_BITS-1:0] wr_set,
    output logic                              wr_en,
    output l1_cache_pkg::frame_t              wr_frame,
    output l1_cache_pkg::frame_mask_t         wr_mask,
    output l1_cache_pkg::mem_op_t             mem_op,
    output l1_cache_pkg::word_t               victim_addr,
    input  logic                              mem_done,
    input  l1_cache_pkg::block_t              mem_rdata,
    output l1_cache_pkg::word_t               hit_rdata,
    output logic                              hit_busy
);

    l1_cache_pkg::cache_state_t        state;
    l1_cache_pkg::cache_state_t        next_state;
    logic [l1_cache_pkg::SET_BITS-1:0] set_cnt;   // clear and flush walk
    logic                              cnt_step;
    logic                              cnt_last;
    logic                              clr_armed;
    logic                              flush_req;
    logic                              flush_pend;
    logic                              access;
    logic                              hit;
    logic                              pass_act;
    l1_cache_pkg::addr_u               victim;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= l1_cache_pkg::IDLE;
            set_cnt   <= '0;
            clr_armed <= 1'b0;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            clr_armed <= 1'b1;   // first clear write one cycle after reset
            if (cnt_step)
                set_cnt <= set_cnt + 1'b1;   // wraps back to 0 after the last set
            if (state == l1_cache_pkg::FLUSH_CACHE)
                flush_req <= 1'b0;
            else if (flush)
                flush_req <= 1'b1;
        end
    end

    assign access     = req.ren || req.wen;
    assign flush_pend = flush || flush_req;
    assign pass_act   = access && dreq.pass;
    assign hit        = !dreq.pass && rd_frame.valid &&
                        (rd_frame.tag == dreq.addr.fields.tag);
    assign cnt_last   = &set_cnt;   // sets are a power of two

    // walk states index by counter, others by request
    assign rd_set = (state == l1_cache_pkg::IDLE || state == l1_cache_pkg::FLUSH_CACHE) ?
                    set_cnt : dreq.addr.fields.set_idx;
    assign wr_set = rd_set;

    assign hit_rdata = rd_frame.data[dreq.addr.fields.word_idx];

    // block address of whatever sits in the selected frame
    always_comb begin
        victim                = '0;
        victim.fields.tag     = rd_frame.tag;
        victim.fields.set_idx = rd_set;
    end

    assign victim_addr = victim.raw;

    always_comb begin
        next_state = state;
        wr_en      = 1'b0;
        wr_frame   = '0;
        wr_mask    = '1;
        mem_op     = l1_cache_pkg::NONE;
        hit_busy   = 1'b1;
        cnt_step   = 1'b0;
        flush_done = 1'b0;

        case (state)
            l1_cache_pkg::IDLE: begin
                if (clr_armed) begin
                    wr_en    = 1'b1;
                    wr_mask  = '0;   // zero the whole frame
                    cnt_step = 1'b1;
                    if (cnt_last)
                        next_state = l1_cache_pkg::HIT;
                end
            end
            l1_cache_pkg::HIT: begin
                if (pass_act) begin
                    // uncached access runs to completion before a flush
                    mem_op = l1_cache_pkg::PASS_OP;
                    if (flush_pend && mem_done)
                        next_state = l1_cache_pkg::FLUSH_CACHE;
                end else if (flush_pend) begin
                    next_state = l1_cache_pkg::FLUSH_CACHE;
                end else if (access && hit) begin
                    hit_busy = 1'b0;
                    if (req.wen) begin
                        wr_en                                   = 1'b1;
                        wr_frame.dirty                          = 1'b1;
                        wr_frame.data[dreq.addr.fields.word_idx] = req.wdata;
                        wr_mask.dirty                           = 1'b0;
                        wr_mask.data[dreq.addr.fields.word_idx]  = dreq.merge_mask;
                    end
                end else if (access) begin
                    if (rd_frame.valid && rd_frame.dirty)
                        next_state = l1_cache_pkg::WB;
                    else
                        next_state = l1_cache_pkg::FETCH;
                end
            end
            l1_cache_pkg::FETCH: begin
                mem_op = l1_cache_pkg::FETCH_OP;
                if (mem_done) begin
                    wr_en          = 1'b1;
                    wr_mask        = '0;
                    wr_frame.valid = 1'b1;
                    wr_frame.tag   = dreq.addr.fields.tag;
                    wr_frame.data  = mem_rdata;
                    next_state     = l1_cache_pkg::HIT;
                end
            end
            l1_cache_pkg::WB: begin
                mem_op = l1_cache_pkg::EVICT_OP;
                if (mem_done) begin
                    // drop valid and dirty, leave data and tag
                    wr_en         = 1'b1;
                    wr_mask.valid = 1'b0;
                    wr_mask.dirty = 1'b0;
                    next_state    = l1_cache_pkg::HIT;
                end
            end
            l1_cache_pkg::FLUSH_CACHE: begin
                if (rd_frame.valid && rd_frame.dirty) begin
                    mem_op   = l1_cache_pkg::FLUSH_OP;
                    cnt_step = mem_done;
                end else begin
                    cnt_step = 1'b1;   // clean set, one cycle
                end
                if (cnt_step) begin
                    wr_en   = 1'b1;
                    wr_mask = '0;
                    if (cnt_last) begin
                        flush_done = 1'b1;
                        next_state = l1_cache_pkg::HIT;
                    end
                end
            end
            default: next_state = l1_cache_pkg::IDLE;
        endcase
    end

    pass_only_in_hit: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_op == l1_cache_pkg::PASS_OP) |-> (state == l1_cache_pkg::HIT));

    // done pulse ends the walk and hands back to HIT
    done_ends_flush: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |-> (state == l1_cache_pkg::FLUSH_CACHE) ##1
                       (state == l1_cache_pkg::HIT));

endmodule

/* rtl/mem_port.sv */
//************************************************
// builds the memory bus request for each controller
// command and steers the processor response
//************************************************
`timescale 1ns/100ps

module mem_port (
    input  l1_cache_pkg::mem_op_t   op,
    input  l1_cache_pkg::dec_req_t  dreq,
    input  l1_cache_pkg::proc_req_t req,
    input  l1_cache_pkg::word_t     lane_wdata,
    input  l1_cache_pkg::word_t     victim_addr,
    input  l1_cache_pkg::block_t    victim_data,
    input  l1_cache_pkg::word_t     hit_rdata,
    input  logic                    hit_busy,
    output l1_cache_pkg::mem_req_t  mem_req,
    input  l1_cache_pkg::mem_rsp_t  mem_rsp,
    output logic                    mem_done,
    output l1_cache_pkg::proc_rsp_t rsp
);

    l1_cache_pkg::addr_u fetch_addr;

    // block aligned fill address
    always_comb begin
        fetch_addr                 = dreq.addr;
        fetch_addr.fields.word_idx = '0;
        fetch_addr.fields.byte_off = '0;
    end

    always_comb begin
        mem_req         = '0;
        mem_req.byte_en = 4'hF;   // whole block unless uncached
        rsp.busy        = hit_busy;
        rsp.rdata       = hit_rdata;

        case (op)
            l1_cache_pkg::FETCH_OP: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = fetch_addr.raw;
            end
            l1_cache_pkg::EVICT_OP, l1_cache_pkg::FLUSH_OP: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = victim_addr;
                mem_req.wdata = victim_data;
            end
            l1_cache_pkg::PASS_OP: begin
                mem_req.ren      = req.ren;
                mem_req.wen      = req.wen;
                mem_req.addr     = dreq.addr.raw;
                mem_req.wdata[0] = lane_wdata;   // lane 0 only
                mem_req.byte_en  = req.byte_en;
                rsp.busy         = mem_rsp.busy;
                rsp.rdata        = mem_rsp.rdata[0];
            end
            default: ;
        endcase
    end

    assign mem_done = (op != l1_cache_pkg::NONE) && !mem_rsp.busy;

    // no read and write on the same memory request
    mem_rw_excl: assert final (!(mem_req.ren && mem_req.wen));

endmodule

/* rtl/l1_cache.sv */
//************************************************
// direct mapped write-back L1 data cache top,
// processor word bus in, block memory bus out
//************************************************
`timescale 1ns/100ps

module l1_cache (
    input  logic                    CLK,
    input  logic                    nRST,
    input  l1_cache_pkg::proc_req_t proc_req,
    output l1_cache_pkg::proc_rsp_t proc_rsp,
    output l1_cache_pkg::mem_req_t  mem_req,
    input  l1_cache_pkg::mem_rsp_t  mem_rsp,
    input  logic                    flush,
    output logic                    flush_done
);

    l1_cache_pkg::dec_req_t            dreq;
    l1_cache_pkg::word_t               lane_wdata;
    l1_cache_pkg::frame_t              rd_frame;
    l1_cache_pkg::frame_t              wr_frame;
    l1_cache_pkg::frame_mask_t         wr_mask;
    logic [l1_cache_pkg::SET_BITS-1:0] rd_set;
    logic [l1_cache_pkg::SET_BITS-1:0] wr_set;
    logic                              wr_en;
    l1_cache_pkg::mem_op_t             mem_op;
    l1_cache_pkg::word_t               victim_addr;
    logic                              mem_done;
    l1_cache_pkg::word_t               hit_rdata;
    logic                              hit_busy;

    req_decoder i_decoder (
        .req        (proc_req),
        .dreq       (dreq),
        .lane_wdata (lane_wdata)
    );

    frame_store i_frames (
        .CLK      (CLK),
        .nRST     (nRST),
        .rd_set   (rd_set),
        .rd_frame (rd_frame),
        .wr_en    (wr_en),
        .wr_set   (wr_set),
        .wr_frame (wr_frame),
        .wr_mask  (wr_mask)
    );

    cache_ctrl i_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .req         (proc_req),
        .dreq        (dreq),
        .flush       (flush),
        .flush_done  (flush_done),
        .rd_frame    (rd_frame),
        .rd_set      (rd_set),
        .wr_set      (wr_set),
        .wr_en       (wr_en),
        .wr_frame    (wr_frame),
        .wr_mask     (wr_mask),
        .mem_op      (mem_op),
        .victim_addr (victim_addr),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rsp.rdata),
        .hit_rdata   (hit_rdata),
        .hit_busy    (hit_busy)
    );

    mem_port i_mem_port (
        .op          (mem_op),
        .dreq        (dreq),
        .req         (proc_req),
        .lane_wdata  (lane_wdata),
        .victim_addr (victim_addr),
        .victim_data (rd_frame.data),
        .hit_rdata   (hit_rdata),
        .hit_busy    (hit_busy),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp),
        .mem_done    (mem_done),
        .rsp         (proc_rsp)
    );

endmodule

/* testbench/tb_mem_model.sv */
//**************************************************
// block memory model for the cache testbench, answers
// each request after 1 to 4 extra cycles
//**************************************************
`timescale 1ns/100ps
`include "l1_cache_cfg.svh"

module tb_mem_model (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::mem_req_t req,
    output l1_cache_pkg::mem_rsp_t rsp
);

    l1_cache_pkg::word_t  mem [l1_cache_pkg::word_t];   // written words only
    l1_cache_pkg::block_t rd_blk;
    logic [15:0]          lfsr;
    logic [15:0]          lfsr_1;
    logic [15:0]          lfsr_2;
    logic [1:0]           wait_cnt;
    logic                 active;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic l1_cache_pkg::word_t read_word(input l1_cache_pkg::word_t a);
        if (mem.exists(a))
            return mem[a];
        return {a[15:0], a[31:16]} ^ (a << 3) ^ 32'h3C5A_96E1;   // fill pattern
    endfunction

    assign lfsr_1 = lfsr_next(lfsr);   // one step per latency bit
    assign lfsr_2 = lfsr_next(lfsr_1);
    assign rsp    = {!(active && wait_cnt == 2'd0), rd_blk};

    always @(posedge CLK or negedge nRST) begin
        l1_cache_pkg::word_t base;
        l1_cache_pkg::word_t merged;
        base = req.addr & ~32'h3;
        if (!nRST) begin
            lfsr     <= 16'd49;
            active   <= 1'b0;
            wait_cnt <= 2'd0;
            rd_blk   <= '0;
        end else if (!active) begin
            if (req.ren || req.wen) begin
                active   <= 1'b1;
                wait_cnt <= {lfsr_2[0], lfsr_1[0]};
                lfsr     <= lfsr_2;
                for (int i = 0; i < `L1_BLOCK_WORDS; i++)
                    rd_blk[i] <= read_word(base + 4 * i);
            end
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            active <= 1'b0;   // busy was low this cycle
            if (req.wen && req.addr >= `L1_NONCACHE_START) begin
                merged = read_word(base);
                for (int b = 0; b < 4; b++)
                    if (req.byte_en[b])
                        merged[8*b +: 8] = req.wdata[0][8*b +: 8];
                mem[base] = merged;   // uncached, lane 0 only
            end else if (req.wen) begin
                for (int i = 0; i < `L1_BLOCK_WORDS; i++)
                    mem[base + 4 * i] = req.wdata[i];
            end
        end
    end

endmodule

/* testbench/tb_l1_cache.sv */
//**************************************************
// table driven testbench for the L1 cache, runs reads,
// writes and flushes and checks them against a shadow
//**************************************************
`timescale 1ns/100ps
`include "l1_cache_cfg.svh"

module tb_l1_cache;

    typedef enum logic [1:0] {RD, WR, FL} row_op_t;

    typedef struct {
        row_op_t             op;
        l1_cache_pkg::word_t addr;
        l1_cache_pkg::word_t wdata;
        logic [3:0]          byte_en;
        l1_cache_pkg::word_t exp;   // used by read rows
    } row_t;

    localparam l1_cache_pkg::word_t BLK_BYTES = `L1_BLOCK_WORDS * 4;
    localparam l1_cache_pkg::word_t SET_SPAN  = `L1_N_SETS * BLK_BYTES;   // same set, next tag
    localparam l1_cache_pkg::word_t IO_BASE   = `L1_NONCACHE_START;

    logic                    CLK = 1'b0;
    logic                    nRST;
    l1_cache_pkg::proc_req_t proc_req;
    l1_cache_pkg::proc_rsp_t proc_rsp;
    l1_cache_pkg::mem_req_t  mem_req;
    l1_cache_pkg::mem_rsp_t  mem_rsp;
    logic                    flush;
    logic                    flush_done;

    row_t                rows [$];
    l1_cache_pkg::word_t shadow [l1_cache_pkg::word_t];
    bit                  dirty_blk [l1_cache_pkg::word_t];   // block addresses
    int                  val_errs   = 0;
    int                  other_errs = 0;
    int                  done_cnt   = 0;
    int                  n_flush    = 0;

    l1_cache i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .proc_req   (proc_req),
        .proc_rsp   (proc_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .flush      (flush),
        .flush_done (flush_done)
    );

    tb_mem_model i_mem (
        .CLK  (CLK),
        .nRST (nRST),
        .req  (mem_req),
        .rsp  (mem_rsp)
    );

    always #50 CLK = ~CLK;

    function automatic l1_cache_pkg::word_t shadow_word(input l1_cache_pkg::word_t a);
        l1_cache_pkg::word_t wa;
        wa = a & ~32'h3;
        if (shadow.exists(wa))
            return shadow[wa];
        return {wa[15:0], wa[31:16]} ^ (wa << 3) ^ 32'h3C5A_96E1;   // memory fill
    endfunction

    function automatic l1_cache_pkg::block_t shadow_block(input l1_cache_pkg::word_t a);
        l1_cache_pkg::block_t b;
        for (int i = 0; i < `L1_BLOCK_WORDS; i++)
            b[i] = shadow_word(a + 4 * i);
        return b;
    endfunction

    // odd byte patterns store the whole word
    function automatic logic [3:0] stored_bytes(input logic [3:0] be);
        case (be)
            4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100: return be;
            default: return 4'hF;
        endcase
    endfunction

    // bus word of an uncached write, other lanes zero
    function automatic l1_cache_pkg::word_t lane_word(input l1_cache_pkg::word_t d,
                                                      input logic [3:0] be);
        l1_cache_pkg::word_t w;
        logic [3:0]          wr_bytes;
        w        = '0;
        wr_bytes = stored_bytes(be);
        for (int b = 0; b < 4; b++)
            if (wr_bytes[b])
                w[8*b +: 8] = d[8*b +: 8];
        return w;
    endfunction

    task automatic merge_write(input l1_cache_pkg::word_t a, input l1_cache_pkg::word_t d,
                               input logic [3:0] be);
        l1_cache_pkg::word_t w;
        logic [3:0]          wr_bytes;
        w        = shadow_word(a);
        wr_bytes = stored_bytes(be);
        for (int b = 0; b < 4; b++)
            if (wr_bytes[b])
                w[8*b +: 8] = d[8*b +: 8];
        shadow[a & ~32'h3] = w;
    endtask

    task automatic check_word(input string name, input l1_cache_pkg::word_t got,
                              input l1_cache_pkg::word_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_block(input string name, input l1_cache_pkg::block_t got,
                               input l1_cache_pkg::block_t exp);
        if (got !== exp) begin
            val_errs++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_pulse(input string name, input int got, input int exp);
        if (got != exp) begin
            val_errs++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic add_row(input row_op_t op, input l1_cache_pkg::word_t addr,
                           input l1_cache_pkg::word_t wdata, input logic [3:0] be);
        row_t r;
        r.op      = op;
        r.addr    = addr;
        r.wdata   = wdata;
        r.byte_en = be;
        r.exp     = shadow_word(addr);
        if (op == WR)
            merge_write(addr, wdata, be);
        if (op == FL)
            n_flush++;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(RD, 32'h0000_1000, 32'h0, 4'hF);   // cold miss, then hits
        add_row(RD, 32'h0000_1000, 32'h0, 4'hF);
        add_row(RD, 32'h0000_1004, 32'h0, 4'hF);
        add_row(WR, 32'h0000_1000, 32'h1122_3344, 4'b0001);
        add_row(WR, 32'h0000_1000, 32'h5566_7788, 4'b0010);
        add_row(WR, 32'h0000_1000, 32'h99AA_BBCC, 4'b0100);
        add_row(WR, 32'h0000_1000, 32'hDDEE_FF00, 4'b1000);
        add_row(RD, 32'h0000_1000, 32'h0, 4'hF);
        add_row(WR, 32'h0000_1004, 32'hCAFE_0123, 4'b0011);
        add_row(WR, 32'h0000_1004, 32'h4567_BEEF, 4'b1100);
        add_row(RD, 32'h0000_1004, 32'h0, 4'hF);
        add_row(WR, 32'h0000_1008, 32'h0BAD_F00D, 4'hF);
        add_row(WR, 32'h0000_100C, 32'h7654_3210, 4'b0110);
        add_row(RD, 32'h0000_1008, 32'h0, 4'hF);
        add_row(RD, 32'h0000_100C, 32'h0, 4'hF);
        add_row(WR, 32'h0000_2010, 32'hA5A5_5A5A, 4'hF);   // dirty, then conflict
        add_row(RD, 32'h0000_2010 + SET_SPAN, 32'h0, 4'hF);
        add_row(RD, 32'h0000_2010, 32'h0, 4'hF);
        add_row(WR, IO_BASE + 32'h10, 32'h0000_00AB, 4'b0001);   // uncached
        add_row(WR, IO_BASE + 32'h10, 32'h1234_0000, 4'b1100);
        add_row(RD, IO_BASE + 32'h10, 32'h0, 4'hF);
        add_row(WR, IO_BASE + 32'h14, 32'hFEED_C0DE, 4'hF);
        add_row(RD, IO_BASE + 32'h14, 32'h0, 4'hF);
        add_row(RD, IO_BASE + 32'h18, 32'h0, 4'hF);
        add_row(WR, 32'h0000_3000, 32'h0102_0304, 4'hF);
        add_row(WR, 32'h0000_3008, 32'h1111_2222, 4'b0011);
        add_row(WR, 32'h0000_3044, 32'h3333_4444, 4'b1000);
        add_row(WR, 32'h0000_2010, 32'h5555_6666, 4'hF);
        add_row(FL, 32'h0, 32'h0, 4'h0);
        add_row(RD, 32'h0000_3000, 32'h0, 4'hF);
        add_row(RD, 32'h0000_3008, 32'h0, 4'hF);
        add_row(RD, 32'h0000_3044, 32'h0, 4'hF);
        add_row(RD, 32'h0000_2010, 32'h0, 4'hF);
        add_row(RD, 32'h0000_1008, 32'h0, 4'hF);
        add_row(FL, 32'h0, 32'h0, 4'h0);   // nothing dirty left
        shadow.delete();   // rebuilt while the rows run
    endtask

    task automatic run_row(input row_t r);
        l1_cache_pkg::word_t got;
        int                  start_cnt;
        if (r.op == FL) begin
            start_cnt = done_cnt;
            flush     = 1'b1;
            @(posedge CLK);
            #10 flush = 1'b0;
            while (!flush_done)
                @(negedge CLK);
            repeat (`L1_N_SETS + 4) @(negedge CLK);   // a second pulse would show here
            check_pulse("flush_done pulses", done_cnt - start_cnt, 1);
            if (dirty_blk.num() != 0) begin
                other_errs++;
                $display("flush left %0d dirty blocks without a writeback", dirty_blk.num());
            end
            @(posedge CLK);
            #10;
        end else begin
            proc_req.ren     = (r.op == RD);
            proc_req.wen     = (r.op == WR);
            proc_req.addr    = r.addr;
            proc_req.wdata   = r.wdata;
            proc_req.byte_en = r.byte_en;
            @(negedge CLK);
            while (proc_rsp.busy)
                @(negedge CLK);
            got = proc_rsp.rdata;
            @(posedge CLK);   // access completes on this edge
            #10;
            proc_req.ren = 1'b0;
            proc_req.wen = 1'b0;
            if (r.op == RD) begin
                check_word("proc_rsp.rdata", got, r.exp);
            end else begin
                merge_write(r.addr, r.wdata, r.byte_en);
                if (r.addr < IO_BASE)
                    dirty_blk[r.addr & ~(BLK_BYTES - 1)] = 1'b1;
            end
        end
    endtask

    // memory writes and flush_done, sampled mid cycle
    always @(negedge CLK) begin
        if (flush_done)
            done_cnt++;
        if (nRST && mem_req.wen && !mem_rsp.busy && mem_req.addr < IO_BASE) begin
            check_block("mem_req.wdata", mem_req.wdata, shadow_block(mem_req.addr));
            if (dirty_blk.exists(mem_req.addr)) begin
                dirty_blk.delete(mem_req.addr);
            end else begin
                other_errs++;
                $display("writeback to %h of a block that holds no written data",
                         mem_req.addr);
            end
        end else if (nRST && mem_req.wen && !mem_rsp.busy) begin
            check_word("mem_req.wdata[0]", mem_req.wdata[0],
                       lane_word(proc_req.wdata, proc_req.byte_en));
        end
    end

    initial begin
        nRST     = 1'b0;
        flush    = 1'b0;
        proc_req = '0;
        build_table();
        repeat (3) @(posedge CLK);
        #10 nRST = 1'b1;
        foreach (rows[i])
            run_row(rows[i]);
        check_pulse("flush_done total", done_cnt, n_flush);
        $display("errors: %0d wrong values, %0d other", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // watchdog
    initial begin
        @(posedge nRST);
        repeat (rows.size() * 40 + 2 * `L1_N_SETS) @(posedge CLK);
        $display("timeout, the DUT stopped responding before all rows were run");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* sources.f */
+incdir+rtl
rtl/l1_cache_pkg.sv
rtl/req_decoder.sv
rtl/frame_store.sv
rtl/cache_ctrl.sv
rtl/mem_port.sv
rtl/l1_cache.sv
testbench/tb_mem_model.sv
testbench/tb_l1_cache.sv

/* run_sim.sh */
#!/bin/sh
# builds the cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_l1_cache \
    -f sources.f -Mdir obj_dir

out=$(./obj_dir/Vtb_l1_cache)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
